/* Bender.yml */
package:
  name: rv_core

sources:
  - include_dirs:
      - src
    files:
      - src/rv_pkg.sv
      - src/rv_fetch_pc.sv
      - src/rv_decode.sv
      - src/rv_regfile.sv
      - src/rv_execute.sv
      - src/rv_core_top.sv
  - target: test
    include_dirs:
      - src
      - tb
    files:
      - tb/tb_rv_core.sv

/* build.f */
+incdir+src
+incdir+tb
src/rv_pkg.sv
src/rv_fetch_pc.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_core_top.sv
tb/tb_rv_core.sv

/* src/rv_core_top.sv */
`timescale 1ns/1ps

`include "rv_defs.svh"

module rv_core_top
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  word_t     inst,
  output word_t     pc,
  output logic      halted,
  output logic      wb_en,
  output reg_addr_t wb_addr,
  output word_t     wb_data
);

  // decode outputs
  reg_addr_t rs1_addr;
  reg_addr_t rd_addr;
  word_t     imm;
  op_a_sel_e op_a_sel;
  wb_sel_e   wb_sel;
  logic      reg_write;
  logic      is_jump;
  logic      is_ebreak;

  // register read / execute
  word_t     rs1_data;
  word_t     jump_target;
  word_t     exe_data;

  // pc and halt state
  rv_fetch_pc u_fetch_pc (
    .clk         (clk),
    .rst_n       (rst_n),
    .is_jump     (is_jump),
    .is_ebreak   (is_ebreak),
    .jump_target (jump_target),
    .pc          (pc),
    .halted      (halted)
  );

  // inst is the word at pc, same cycle
  rv_decode u_decode (
    .inst      (inst),
    .rs1_addr  (rs1_addr),
    .rd_addr   (rd_addr),
    .imm       (imm),
    .op_a_sel  (op_a_sel),
    .wb_sel    (wb_sel),
    .reg_write (reg_write),
    .is_jump   (is_jump),
    .is_ebreak (is_ebreak)
  );

  // halted core commits nothing
  assign wb_en   = reg_write & ~halted;
  assign wb_addr = rd_addr;
  assign wb_data = exe_data;

  rv_regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (rs1_addr),
    .rs1_data (rs1_data),
    .we       (wb_en),
    .waddr    (rd_addr),
    .wdata    (exe_data)
  );

  rv_execute u_execute (
    .pc          (pc),
    .rs1_data    (rs1_data),
    .imm         (imm),
    .op_a_sel    (op_a_sel),
    .wb_sel      (wb_sel),
    .wb_data     (exe_data),
    .jump_target (jump_target)
  );

endmodule

/* src/rv_decode.sv */
`timescale 1ns/1ps

`include "rv_defs.svh"

module rv_decode
  import rv_pkg::*;
(
  input  word_t     inst,
  output reg_addr_t rs1_addr,
  output reg_addr_t rd_addr,
  output word_t     imm,
  output op_a_sel_e op_a_sel,
  output wb_sel_e   wb_sel,
  output logic      reg_write,
  output logic      is_jump,
  output logic      is_ebreak
);

  opcode_e     opcode;
  logic [2:0]  funct3;
  word_t       imm_i;
  word_t       imm_u;
  word_t       imm_j;
  logic        writes_rd;

  // fixed field positions
  assign opcode   = opcode_e'(inst[6:0]);
  assign rd_addr  = inst[11:7];
  assign funct3   = inst[14:12];
  assign rs1_addr = inst[19:15];

  // immediates, all sign-extended from inst[31]
  // i type: addi, jalr
  assign imm_i = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
  // u type, already placed in the upper 20 bits
  assign imm_u = {inst[31:12], 12'h000};
  // j type, scrambled bits, lsb always zero
  assign imm_j = {{(`RV_XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // per-opcode control
  always_comb begin
    // no-op defaults: no write, no jump, pc + 4
    imm       = '0;
    op_a_sel  = op_a_rs1;
    wb_sel    = wb_sum;
    writes_rd = 1'b0;
    is_jump   = 1'b0;
    is_ebreak = 1'b0;

    case (opcode)
      op_imm: begin
        // only addi, other funct3 fall to no-op
        if (funct3 == 3'b000) begin
          imm       = imm_i;
          writes_rd = 1'b1;
        end
      end
      op_lui: begin
        // 0 + imm_u
        imm       = imm_u;
        op_a_sel  = op_a_zero;
        writes_rd = 1'b1;
      end
      op_auipc: begin
        imm       = imm_u;
        op_a_sel  = op_a_pc;
        writes_rd = 1'b1;
      end
      op_jal: begin
        // target pc + imm_j, link pc + 4
        imm       = imm_j;
        op_a_sel  = op_a_pc;
        wb_sel    = wb_pc_plus4;
        writes_rd = 1'b1;
        is_jump   = 1'b1;
      end
      op_jalr: begin
        // target rs1 + imm_i, bit 0 dropped in execute
        if (funct3 == 3'b000) begin
          imm       = imm_i;
          op_a_sel  = op_a_rs1;
          wb_sel    = wb_pc_plus4;
          writes_rd = 1'b1;
          is_jump   = 1'b1;
        end
      end
      op_system: begin
        // exact ebreak encoding only, ecall and csr ops are no-ops
        is_ebreak = (inst[31:7] == 25'h000_2000);
      end
      default: begin
        // loads, stores, branches, r type
      end
    endcase
  end

  // writes to x0 are discarded here
  assign reg_write = writes_rd && (rd_addr != '0);

endmodule

/* src/rv_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data path and address width
`define RV_XLEN 32

// architectural integer registers, x0 included
`define RV_REG_COUNT 32

// first fetch address after reset
`define RV_RESET_PC 32'h8000_0000

// sequential pc step, one 32-bit instruction
`define RV_INST_BYTES 4

// major opcodes, bits [6:0] of the instruction
`define RV_OP_IMM 7'b001_0011
`define RV_OP_AUIPC 7'b001_0111
`define RV_OP_LUI 7'b011_0111
`define RV_OP_JAL 7'b110_1111
`define RV_OP_JALR 7'b110_0111
// ecall / ebreak / csr space
`define RV_OP_SYSTEM 7'b111_0011

`endif

/* src/rv_execute.sv */
`timescale 1ns/1ps

`include "rv_defs.svh"

module rv_execute
  import rv_pkg::*;
(
  input  word_t     pc,
  input  word_t     rs1_data,
  input  word_t     imm,
  input  op_a_sel_e op_a_sel,
  input  wb_sel_e   wb_sel,
  output word_t     wb_data,
  output word_t     jump_target
);

  word_t op_a;
  word_t sum;
  word_t pc_plus4;

  // operand a select
  always_comb begin
    case (op_a_sel)
      op_a_rs1:  op_a = rs1_data;
      op_a_pc:   op_a = pc;
      // lui, and the unused encoding
      default:   op_a = '0;
    endcase
  end

  // the one shared adder
  // addi, lui, auipc result and jal / jalr target
  assign sum = op_a + imm;

  // link address
  assign pc_plus4 = pc + word_t'(`RV_INST_BYTES);

  // bit 0 cleared as jalr requires
  // jal sums are already even
  assign jump_target = {sum[`RV_XLEN-1:1], 1'b0};

  // writeback data select
  always_comb begin
    case (wb_sel)
      wb_pc_plus4: wb_data = pc_plus4;
      default:     wb_data = sum;
    endcase
  end

endmodule

/* src/rv_fetch_pc.sv */
`timescale 1ns/1ps

`include "rv_defs.svh"

module rv_fetch_pc
  import rv_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  is_jump,
  input  logic  is_ebreak,
  input  word_t jump_target,
  output word_t pc,
  output logic  halted
);

  core_state_e state;
  word_t       pc_seq;
  word_t       next_pc;

  // sequential successor
  assign pc_seq = pc + word_t'(`RV_INST_BYTES);

  // jal / jalr redirect, else fall through
  assign next_pc = is_jump ? jump_target : pc_seq;

  assign halted = (state == core_halt);

  // pc register and run/halt state
  // one instruction retires per edge while running
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc    <= `RV_RESET_PC;
      state <= core_run;
    end else begin
      if (state == core_run) begin
        // the ebreak itself still steps the pc like any no-op
        pc <= next_pc;
        if (is_ebreak) begin
          state <= core_halt;
        end
      end
      // core_halt is sticky, only reset leaves it
    end
  end

  // targets come from decode and execute, keep them word aligned
  a_pc_aligned : assert property (
    @(posedge clk) disable iff (!rst_n)
    !halted |-> (pc[1:0] == 2'b00)
  ) else $error("pc %h not word aligned", pc);

  // once halted nothing may move the pc
  a_pc_hold_halted : assert property (
    @(posedge clk) disable iff (!rst_n)
    halted |=> $stable(pc)
  ) else $error("pc changed while halted");

endmodule

/* src/rv_pkg.sv */
`include "rv_defs.svh"

package rv_pkg;

  // one machine word: instruction, data or address
  typedef logic [`RV_XLEN-1:0] word_t;

  // register index, 5 bits for 32 registers
  typedef logic [$clog2(`RV_REG_COUNT)-1:0] reg_addr_t;

  // opcodes the core acts on
  // anything else decodes to a no-op
  typedef enum logic [6:0] {
    op_imm    = `RV_OP_IMM,
    op_auipc  = `RV_OP_AUIPC,
    op_lui    = `RV_OP_LUI,
    op_jal    = `RV_OP_JAL,
    op_jalr   = `RV_OP_JALR,
    op_system = `RV_OP_SYSTEM
  } opcode_e;

  // run/halt machine in the fetch stage
  typedef enum logic {
    core_run  = 1'b0,
    core_halt = 1'b1
  } core_state_e;

  // adder operand a source
  typedef enum logic [1:0] {
    op_a_rs1  = 2'd0,
    // auipc, jal
    op_a_pc   = 2'd1,
    // lui
    op_a_zero = 2'd2
  } op_a_sel_e;

  // writeback value source
  typedef enum logic {
    wb_sum      = 1'b0,
    // link address for jal / jalr
    wb_pc_plus4 = 1'b1
  } wb_sel_e;

endpackage

/* src/rv_regfile.sv */
`timescale 1ns/1ps

`include "rv_defs.svh"

module rv_regfile
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t rs1_addr,
  output word_t     rs1_data,
  input  logic      we,
  input  reg_addr_t waddr,
  input  word_t     wdata
);

  // x1..x31, x0 has no storage
  word_t regs [1:`RV_REG_COUNT-1];

  // synchronous write port
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // combinational read, x0 hardwired to zero
  always_comb begin
    if (rs1_addr == '0) begin
      rs1_data = '0;
    end else begin
      rs1_data = regs[rs1_addr];
    end
  end

  // decode masks rd == 0 before the write enable reaches here
  a_no_x0_write : assert property (
    @(posedge clk) disable iff (!rst_n)
    we |-> (waddr != '0)
  ) else $error("write enable asserted for x0");

endmodule

/* tb/rv_core_tests.svh */
`ifndef RV_CORE_TESTS_SVH
`define RV_CORE_TESTS_SVH

// first check sees the reset pc
// nops commit nothing
task automatic reset_and_nop();
  repeat (4) begin
    issue_and_check("reset_and_nop", NOP_WORD, 1'b0, '0, '0, model_pc + STEP);
  end
endtask

task automatic addi_random();
  word_t       r;
  reg_addr_t   rd;
  reg_addr_t   rs1;
  logic [11:0] imm;
  word_t       expected;
  // write to x0 dropped and x0 read back as zero
  issue_and_check("addi_x0", itype_inst(`RV_OP_IMM, 5'd0, 5'd0, 12'h123),
                  1'b0, '0, '0, model_pc + STEP);
  issue_and_check("addi_x0", itype_inst(`RV_OP_IMM, 5'd9, 5'd0, 12'h855),
                  1'b1, 5'd9, 32'hffff_f855, model_pc + STEP);
  for (int n = 0; n < 40; n++) begin
    r   = next_random();
    rd  = r[4:0];
    rs1 = r[9:5];
    imm = r[21:10];
    // sign extend from imm bit 11
    expected = model_regs[rs1] + {{(`RV_XLEN-12){imm[11]}}, imm};
    issue_and_check("addi_random", itype_inst(`RV_OP_IMM, rd, rs1, imm),
                    rd != 5'd0, rd, expected, model_pc + STEP);
  end
endtask

task automatic upper_immediates();
  word_t       r;
  reg_addr_t   rd;
  logic [19:0] imm;
  for (int n = 0; n < 4; n++) begin
    r   = next_random();
    rd  = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
    imm = r[31:12];
    issue_and_check("lui", utype_inst(`RV_OP_LUI, rd, imm),
                    1'b1, rd, {imm, 12'h000}, model_pc + STEP);
    r   = next_random();
    rd  = (r[4:0] == 5'd0) ? 5'd2 : r[4:0];
    imm = r[31:12];
    // offset relative to the auipc itself
    issue_and_check("auipc", utype_inst(`RV_OP_AUIPC, rd, imm),
                    1'b1, rd, model_pc + {imm, 12'h000}, model_pc + STEP);
  end
endtask

task automatic jumps_and_links();
  word_t       r;
  reg_addr_t   rd;
  logic [20:0] off;
  word_t       target;
  // word multiples keep pc aligned
  // rd may be x0
  for (int n = 0; n < 4; n++) begin
    r   = next_random();
    rd  = r[4:0];
    off = {r[25:7], 2'b00};
    target = model_pc + {{(`RV_XLEN-21){off[20]}}, off};
    issue_and_check("jal", jal_inst(rd, off), rd != 5'd0, rd, model_pc + STEP, target);
  end
  // base register near the reset region
  issue_and_check("jalr", utype_inst(`RV_OP_LUI, 5'd10, 20'h80001),
                  1'b1, 5'd10, 32'h8000_1000, model_pc + STEP);
  // odd sum with bit 0 dropped
  target = (model_regs[10] + 32'h0000_0011) & ~32'h1;
  issue_and_check("jalr", itype_inst(`RV_OP_JALR, 5'd1, 5'd10, 12'h011),
                  1'b1, 5'd1, model_pc + STEP, target);
  // negative offset
  // rd equal to rs1 uses the old base
  target = (model_regs[10] + 32'hffff_fff4) & ~32'h1;
  issue_and_check("jalr", itype_inst(`RV_OP_JALR, 5'd10, 5'd10, 12'hff4),
                  1'b1, 5'd10, model_pc + STEP, target);
  // link value as base with an odd negative sum
  target = (model_regs[1] + 32'hffff_fffd) & ~32'h1;
  issue_and_check("jalr", itype_inst(`RV_OP_JALR, 5'd3, 5'd1, 12'hffd),
                  1'b1, 5'd3, model_pc + STEP, target);
endtask

// none of these commit or redirect
task automatic unsupported_opcodes();
  // sw x5, 8(x6)
  issue_and_check("store", {7'd0, 5'd5, 5'd6, 3'b010, 5'd8, 7'b010_0011},
                  1'b0, '0, '0, model_pc + STEP);
  // beq x1, x1, +8 would be taken on a full core
  issue_and_check("branch", {1'b0, 6'd0, 5'd1, 5'd1, 3'b000, 4'b0100, 1'b0, 7'b110_0011},
                  1'b0, '0, '0, model_pc + STEP);
  // add x7, x1, x2
  issue_and_check("r_type_add", {7'd0, 5'd2, 5'd1, 3'b000, 5'd7, 7'b011_0011},
                  1'b0, '0, '0, model_pc + STEP);
  // xori x8, x1, 5
  issue_and_check("op_imm_funct3_100", {12'd5, 5'd1, 3'b100, 5'd8, `RV_OP_IMM},
                  1'b0, '0, '0, model_pc + STEP);
endtask

task automatic ebreak_halt();
  word_t     r;
  reg_addr_t rd;
  // ebreak itself steps like a nop
  issue_and_check("ebreak", EBREAK_WORD, 1'b0, '0, '0, model_pc + STEP);
  model_halted = 1'b1;
  repeat (10) begin
    r  = next_random();
    rd = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
    issue_and_check("halted", itype_inst(`RV_OP_IMM, rd, r[9:5], r[21:10]),
                    1'b0, '0, '0, model_pc);
  end
  apply_reset();
  // x3 held a nonzero link address before reset
  issue_and_check("after_reset", itype_inst(`RV_OP_IMM, 5'd2, 5'd3, 12'h00c),
                  1'b1, 5'd2, 32'h0000_000c, model_pc + STEP);
endtask

`endif

/* tb/tb_rv_core.sv */
`timescale 1ns/1ps

`include "rv_defs.svh"

module tb_rv_core
  import rv_pkg::*;
();

  localparam int    CLK_PERIOD     = 40;
  localparam int    RESET_CYCLES   = 5;
  // directed sequence is well under 200 cycles
  localparam int    TIMEOUT_CYCLES = 2000;
  localparam word_t STEP           = `RV_INST_BYTES;
  // addi x0, x0, 0
  localparam word_t NOP_WORD       = {25'h0, `RV_OP_IMM};
  localparam word_t EBREAK_WORD    = {12'h001, 13'h0000, `RV_OP_SYSTEM};

  logic      clk;
  logic      rst_n;
  word_t     inst;
  word_t     pc;
  logic      halted;
  logic      wb_en;
  reg_addr_t wb_addr;
  word_t     wb_data;

  // reference model where the x0 entry stays zero
  word_t model_regs [`RV_REG_COUNT];
  word_t model_pc;
  logic  model_halted;
  word_t rng_state   = 32'hb85f46ba;
  int    cycle_count = 0;

  rv_core_top u_rv_core_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .inst    (inst),
    .pc      (pc),
    .halted  (halted),
    .wb_en   (wb_en),
    .wb_addr (wb_addr),
    .wb_data (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // hard stop if the sequence never completes
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the test sequence did not finish within %0d cycles", cycle_count);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  // xorshift32
  function automatic word_t next_random();
    word_t x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // i type with funct3 000 for addi and jalr
  function automatic word_t itype_inst(input logic [6:0] opcode, input reg_addr_t rd,
                                       input reg_addr_t rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, opcode};
  endfunction

  // u type for lui and auipc
  function automatic word_t utype_inst(input logic [6:0] opcode, input reg_addr_t rd,
                                       input logic [19:0] imm);
    return {imm, rd, opcode};
  endfunction

  // byte offset without bit 0
  function automatic word_t jal_inst(input reg_addr_t rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
  endfunction

  task automatic report_mismatch(input string test_name, input string what,
                                 input word_t expected, input word_t actual);
    $display("ERROR: %s %s expected %h actual %h", test_name, what, expected, actual);
    $display("Simulation failed");
    $fatal(1, "mismatch in %s", test_name);
  endtask

  // entered and left right after a rising edge
  task automatic apply_reset();
    rst_n <= 1'b0;
    inst  <= NOP_WORD;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    foreach (model_regs[i]) begin
      model_regs[i] = '0;
    end
    model_pc     = `RV_RESET_PC;
    model_halted = 1'b0;
  endtask

  // one instruction per cycle
  // driven at the edge and checked mid-cycle
  // model moves at the next edge
  task automatic issue_and_check(input string test_name, input word_t instr,
                                 input logic exp_en, input reg_addr_t exp_rd,
                                 input word_t exp_data, input word_t exp_next_pc);
    inst <= instr;
    @(negedge clk);
    assert (pc === model_pc)
      else report_mismatch(test_name, "pc", model_pc, pc);
    assert (halted === model_halted)
      else report_mismatch(test_name, "halted", word_t'(model_halted), word_t'(halted));
    assert (wb_en === exp_en)
      else report_mismatch(test_name, "wb_en", word_t'(exp_en), word_t'(wb_en));
    if (exp_en) begin
      assert (wb_addr === exp_rd)
        else report_mismatch(test_name, "wb_addr", word_t'(exp_rd), word_t'(wb_addr));
      assert (wb_data === exp_data)
        else report_mismatch(test_name, "wb_data", exp_data, wb_data);
    end
    @(posedge clk);
    if (exp_en) begin
      model_regs[exp_rd] = exp_data;
    end
    model_pc = exp_next_pc;
  endtask

  `include "rv_core_tests.svh"

  initial begin
    rst_n = 1'b0;
    inst  = NOP_WORD;
    apply_reset();
    reset_and_nop();
    addi_random();
    upper_immediates();
    jumps_and_links();
    unsupported_opcodes();
    ebreak_halt();
    $display("Simulation passed");
    $finish;
  end

endmodule
